/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_vdp
RTL_TOP   ?= vdp_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "test passed" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
vdp_pkg.sv
vdp_vga_timing.sv
vdp_vram.sv
vdp_tile_fetch.sv
vdp_palette.sv
vdp_video_out.sv
vdp_top.sv
tb_clock_gen.sv
tb_vdp.sv

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 10 ns clock, reset held high for the first 4 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int half_period = 5;
    localparam int reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;   // Same 1 ns offset as the other stimulus
    end

endmodule

/* tb_vdp.sv */
// Testbench for the video display processor
// Loads host writes and expected colours from the pattern file, then checks
// reset state, blanking, sync and frame geometry and sampled pixel colours

`timescale 1ns/1ps

module tb_vdp;
    import vdp_pkg::*;

    localparam int frame_len = h_size * v_size;
    localparam int screen_pixels = h_active * v_active;
    localparam int timeout_cycles = 3 * frame_len + 200;
    localparam int max_words = 256;
    localparam int reset_hold = pixel_latency + 2;   // Cycles after reset with idle outputs
    localparam int first_de = h_offscreen + pixel_latency + 1;   // Cycles before de can rise

    logic                 clk;
    logic                 rst;
    logic                 wr_en;
    logic [target_w-1:0]  wr_target;
    logic [wr_addr_w-1:0] wr_addr;
    logic [wr_data_w-1:0] wr_data;
    logic                 hsync;
    logic                 vsync;
    logic                 de;
    logic [rgb_w-1:0]     rgb;

    logic [15:0]      stim_words [max_words];
    logic [rgb_w-1:0] expected_rgb [screen_pixels];
    logic             check_here [screen_pixels];
    int               num_writes;
    int               num_checks;
    int               check_base;
    logic             writes_done = 1'b0;
    int               cycle_count = 0;

    // Monitor state
    logic prev_hsync = 1'b1;
    logic prev_vsync = 1'b1;
    logic prev_de = 1'b0;
    logic hs_fall, hs_rise, vs_fall, vs_rise, de_fall;
    logic window = 1'b0;
    logic frame_open = 1'b0;
    logic line_tracked = 1'b0;
    int   since_reset = 0;
    int   frame_cycles, line_cycles, hsync_low, vsync_low;
    int   de_run, de_runs, de_total, pixel_index;
    int   frames_checked = 0;
    int   pixels_checked = 0;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    vdp_top u_vdp_top (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_target (wr_target),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .rgb       (rgb)
    );

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string signal, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR at %0t ns: %s expected %0d ('h%0h), got %0d ('h%0h)",
                 $time, signal, expected, expected, actual, actual);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("At %0t ns: %s", $time, what);
        stop_with_failure();
    endtask

    // Word 0 is the write count, triples follow, then the check count and its triples
    task automatic load_patterns();
        int idx;
        int x;
        int y;
        $readmemh("vdp_patterns.hex", stim_words);
        assert (^stim_words[0] !== 1'bx) else report_problem("pattern file missing or empty");
        num_writes = int'(stim_words[0]);
        check_base = 1 + 3 * num_writes;
        assert (check_base < max_words && ^stim_words[check_base] !== 1'bx)
            else report_problem("pattern file has no check count after the writes");
        num_checks = int'(stim_words[check_base]);
        assert (check_base + 3 * num_checks < max_words)
            else report_problem("pattern file is longer than the stimulus buffer");
        for (idx = 0; idx < screen_pixels; idx++)
            check_here[idx] = 1'b0;
        for (idx = 0; idx < num_checks; idx++) begin
            x = int'(stim_words[check_base + 1 + 3 * idx]);
            y = int'(stim_words[check_base + 2 + 3 * idx]);
            assert (x < h_active && y < v_active) else report_problem("check position off screen");
            expected_rgb[y * h_active + x] = stim_words[check_base + 3 + 3 * idx][rgb_w-1:0];
            check_here[y * h_active + x] = 1'b1;
        end
    endtask

    task automatic issue_writes();
        int base;
        for (int idx = 0; idx < num_writes; idx++) begin
            base = 1 + 3 * idx;
            wr_en = 1'b1;
            wr_target = stim_words[base][target_w-1:0];
            wr_addr = stim_words[base + 1][wr_addr_w-1:0];
            wr_data = stim_words[base + 2];
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
    endtask

    initial begin
        wr_en = 1'b0;
        wr_target = '0;
        wr_addr = '0;
        wr_data = '0;
        load_patterns();
        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        issue_writes();
        writes_done = 1'b1;
        wait (frames_checked == 2);
        if (pixels_checked == 2 * num_checks) begin
            $display("test passed");
        end else begin
            report_problem("some sampled positions were never reached by de");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
            report_problem("timeout, two checked frames did not complete");
    end

    // Outputs change on the rising edge, so they are sampled on the falling edge
    always @(negedge clk) begin
        hs_fall = prev_hsync && !hsync;
        hs_rise = !prev_hsync && hsync;
        vs_fall = prev_vsync && !vsync;
        vs_rise = !prev_vsync && vsync;
        de_fall = prev_de && !de;

        assert (de || rgb == '0) else report_mismatch("rgb (blanked)", 0, rgb);
        assert (!(de && !hsync)) else report_problem("hsync low while de is high");
        assert (!(de && !vsync)) else report_problem("vsync low while de is high");

        if (rst || since_reset < reset_hold) begin
            assert (hsync === 1'b1) else report_mismatch("hsync", 1, hsync);
            assert (vsync === 1'b1) else report_mismatch("vsync", 1, vsync);
        end
        if (rst || since_reset < first_de) begin
            assert (de === 1'b0) else report_mismatch("de", 0, de);
        end
        since_reset = rst ? 0 : since_reset + 1;

        if (!window && vs_fall && writes_done)
            window = 1'b1;
        if (window) begin
            frame_cycles++;
            line_cycles++;
            if (vs_fall) begin
                if (frame_open) begin
                    assert (frame_cycles == frame_len)
                        else report_mismatch("frame length", frame_len, frame_cycles);
                    assert (de_total == screen_pixels)
                        else report_mismatch("de cycles per frame", screen_pixels, de_total);
                    assert (de_runs == v_active)
                        else report_mismatch("de runs per frame", v_active, de_runs);
                    frames_checked++;
                end
                frame_open = 1'b1;
                frame_cycles = 0;
                vsync_low = 0;
                de_run = 0;
                de_runs = 0;
                de_total = 0;
                pixel_index = 0;
            end
            if (!vsync)
                vsync_low++;
            if (vs_rise && frame_open) begin
                assert (vsync_low == v_sync * h_size)
                    else report_mismatch("vsync low width", v_sync * h_size, vsync_low);
            end

            if (hs_fall) begin
                if (line_tracked) begin
                    assert (line_cycles == h_size)
                        else report_mismatch("hsync period", h_size, line_cycles);
                end
                line_tracked = 1'b1;
                line_cycles = 0;
                hsync_low = 0;
            end
            if (!hsync)
                hsync_low++;
            if (hs_rise && line_tracked) begin
                assert (hsync_low == h_sync) else report_mismatch("hsync low width", h_sync, hsync_low);
            end

            if (de && frame_open) begin
                de_run++;
                de_total++;
                if (pixel_index < screen_pixels && check_here[pixel_index]) begin
                    assert (rgb == expected_rgb[pixel_index])
                        else report_mismatch("rgb", expected_rgb[pixel_index], rgb);
                    pixels_checked++;
                end
                pixel_index++;
            end
            if (de_fall && frame_open) begin
                assert (de_run == h_active) else report_mismatch("de run length", h_active, de_run);
                de_runs++;
                de_run = 0;
            end
            if (frames_checked == 2)
                window = 1'b0;
        end

        prev_hsync = hsync;
        prev_vsync = vsync;
        prev_de = de;
    end

endmodule

/* vdp_palette.sv */
// Execute stage of the pixel pipeline
// Host-writable colour table with a registered lookup

`timescale 1ns/1ps

module vdp_palette (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic [vdp_pkg::target_w-1:0]   wr_target,
    input  logic [vdp_pkg::wr_addr_w-1:0]  wr_addr,
    input  logic [vdp_pkg::wr_data_w-1:0]  wr_data,
    input  logic [vdp_pkg::pal_addr_w-1:0] pixel,
    output logic [vdp_pkg::rgb_w-1:0]      rgb
);
    import vdp_pkg::*;

    logic [rgb_w-1:0] colours [2**pal_addr_w];   // 4 bits each of R, G, B

    always_ff @(posedge clk) begin
        if (wr_en && wr_target == target_palette)
            colours[wr_addr[pal_addr_w-1:0]] <= wr_data[rgb_w-1:0];
    end

    always_ff @(posedge clk) begin
        rgb <= colours[pixel];
    end

endmodule

/* vdp_patterns.hex */
// Write count, then per write: target (0 map, 1 pattern, 2 palette), address, data
// Check count, then per check: screen x, screen y, expected rgb
001C
// Tile map, entry = flip bit 6, bank bits 5..4, tile bits 3..0
0 00 0000   0 01 0011   0 02 0042   0 03 0013
0 04 0001   0 05 0050   0 06 0003   0 07 0012
0 08 0002   0 09 0053   0 0A 0010   0 0B 0041
// Pattern rows 0 and 7 of tiles 0 to 3
1 00 4002   1 07 C001   1 08 8003   1 0F 0002
1 10 C000   1 17 4003   1 18 0001   1 1F 8000
// Palette banks 0 and 1
2 00 000F   2 01 00F0   2 02 0F00   2 03 0FFF
2 04 0123   2 05 0456   2 06 0789   2 07 0ABC
0030
// Four corners per tile, tiles in map order
00 00 0F0   07 00 F00   00 07 FFF   07 07 0F0
08 00 789   0F 00 ABC   08 07 123   0F 07 789
10 00 00F   17 00 FFF   10 07 FFF   17 07 0F0
18 00 123   1F 00 456   18 07 789   1F 07 123
00 08 F00   07 08 FFF   00 0F 00F   07 0F F00
08 08 789   0F 08 456   08 0F 456   0F 0F ABC
10 08 00F   17 08 0F0   10 0F F00   17 0F 00F
18 08 ABC   1F 08 123   18 0F 456   1F 0F ABC
00 10 FFF   07 10 00F   00 17 0F0   07 17 FFF
08 10 456   0F 10 123   08 17 123   0F 17 789
10 10 456   17 10 789   10 17 ABC   17 17 456
18 10 FFF   1F 10 F00   18 17 F00   1F 17 00F

/* vdp_pkg.sv */
// Shared constants for the video display processor
// Raster timing, screen layout, memory widths, host write targets
// and the pixel pipeline latency

package vdp_pkg;

    // Horizontal timing in pixels
    localparam int h_active = 32;
    localparam int h_frontporch = 4;
    localparam int h_sync = 8;
    localparam int h_backporch = 8;
    localparam int h_size = h_active + h_frontporch + h_sync + h_backporch;
    localparam int h_offscreen = h_size - h_active;    // First active column

    // Vertical timing in lines
    localparam int v_active = 24;
    localparam int v_frontporch = 2;
    localparam int v_sync = 3;
    localparam int v_backporch = 5;
    localparam int v_size = v_active + v_frontporch + v_sync + v_backporch;

    localparam int raster_x_w = 6;
    localparam int raster_y_w = 6;

    // Phase codes shared by both raster state machines
    localparam logic [1:0] phase_fp = 2'd0;
    localparam logic [1:0] phase_sync = 2'd1;
    localparam logic [1:0] phase_bp = 2'd2;
    localparam logic [1:0] phase_active = 2'd3;

    localparam int tile_size = 8;
    localparam int tile_bits = $clog2(tile_size);
    localparam int map_cols = 4;
    localparam int map_rows = 3;

    localparam int map_addr_w = 4;
    localparam int map_data_w = 8;
    localparam int pat_addr_w = 7;
    localparam int pat_data_w = 16;    // 8 pixels, leftmost in the high bits
    localparam int pal_addr_w = 4;
    localparam int rgb_w = 12;

    localparam int wr_addr_w = 7;
    localparam int wr_data_w = 16;
    localparam int target_w = 2;
    localparam logic [target_w-1:0] target_map = 2'd0;
    localparam logic [target_w-1:0] target_pattern = 2'd1;
    localparam logic [target_w-1:0] target_palette = 2'd2;

    localparam int pixel_latency = 4;  // Raster position to palette output

endpackage

/* vdp_tile_fetch.sv */
// Decode stage of the pixel pipeline
// Raster position to tile-map address, entry to pattern address,
// pattern row to a banked pixel index, three cycles in all

`timescale 1ns/1ps

module vdp_tile_fetch (
    input  logic                           clk,
    input  logic [vdp_pkg::raster_x_w-1:0] raster_x,
    input  logic [vdp_pkg::raster_y_w-1:0] raster_y,
    output logic [vdp_pkg::map_addr_w-1:0] map_raddr,
    input  logic [vdp_pkg::map_data_w-1:0] map_rdata,
    output logic [vdp_pkg::pat_addr_w-1:0] pat_raddr,
    input  logic [vdp_pkg::pat_data_w-1:0] pat_rdata,
    output logic [vdp_pkg::pal_addr_w-1:0] pixel
);
    import vdp_pkg::*;

    logic [raster_x_w-1:0] screen_x;
    logic [raster_x_w-1:0] tile_col;
    logic [raster_y_w-1:0] tile_row;
    logic [tile_bits-1:0]  fine_x_q1;
    logic [tile_bits-1:0]  fine_y_q1;
    logic [tile_bits-1:0]  fine_x_q2;
    logic                  flip_q2;
    logic [1:0]            bank_q2;
    logic [tile_bits-1:0]  sel;

    // Cycle 0, map address from the tile column and row
    assign screen_x = raster_x - raster_x_w'(h_offscreen);
    assign tile_col = screen_x >> tile_bits;
    assign tile_row = raster_y >> tile_bits;
    assign map_raddr = map_addr_w'(tile_row * map_cols + tile_col);

    always_ff @(posedge clk) begin
        fine_x_q1 <= screen_x[tile_bits-1:0];
        fine_y_q1 <= raster_y[tile_bits-1:0];
    end

    // Cycle 1, entry is back: index in bits 3..0, bank 5..4, flip 6
    assign pat_raddr = pat_addr_w'(map_rdata[3:0] * tile_size + fine_y_q1);

    always_ff @(posedge clk) begin
        fine_x_q2 <= fine_x_q1;
        flip_q2 <= map_rdata[6];
        bank_q2 <= map_rdata[5:4];
    end

    // Cycle 2, leftmost pixel sits in the top bits unless flipped
    assign sel = flip_q2 ? fine_x_q2 : ~fine_x_q2;

    always_ff @(posedge clk) begin
        pixel <= {bank_q2, pat_rdata[{sel, 1'b0} +: 2]};
    end

endmodule

/* vdp_top.sv */
// Video display processor top level
// Raster timing, video memory, tile fetch, palette and video output

`timescale 1ns/1ps

module vdp_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  logic [vdp_pkg::target_w-1:0]  wr_target,
    input  logic [vdp_pkg::wr_addr_w-1:0] wr_addr,
    input  logic [vdp_pkg::wr_data_w-1:0] wr_data,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          de,
    output logic [vdp_pkg::rgb_w-1:0]     rgb
);
    import vdp_pkg::*;

    logic [raster_x_w-1:0] raster_x;
    logic [raster_y_w-1:0] raster_y;
    logic                  timing_hsync;
    logic                  timing_vsync;
    logic                  active_display;
    logic [map_addr_w-1:0] map_raddr;
    logic [map_data_w-1:0] map_rdata;
    logic [pat_addr_w-1:0] pat_raddr;
    logic [pat_data_w-1:0] pat_rdata;
    logic [pal_addr_w-1:0] pixel;
    logic [rgb_w-1:0]      pal_rgb;

    vdp_vga_timing u_vga_timing (
        .clk            (clk),
        .rst            (rst),
        .raster_x       (raster_x),
        .raster_y       (raster_y),
        .line_ended     (),
        .frame_ended    (),
        .hsync          (timing_hsync),
        .vsync          (timing_vsync),
        .active_display (active_display)
    );

    vdp_vram u_vram (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_target (wr_target),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .map_raddr (map_raddr),
        .map_rdata (map_rdata),
        .pat_raddr (pat_raddr),
        .pat_rdata (pat_rdata)
    );

    vdp_tile_fetch u_tile_fetch (
        .clk       (clk),
        .raster_x  (raster_x),
        .raster_y  (raster_y),
        .map_raddr (map_raddr),
        .map_rdata (map_rdata),
        .pat_raddr (pat_raddr),
        .pat_rdata (pat_rdata),
        .pixel     (pixel)
    );

    vdp_palette u_palette (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_target (wr_target),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .pixel     (pixel),
        .rgb       (pal_rgb)
    );

    vdp_video_out u_video_out (
        .clk       (clk),
        .rst       (rst),
        .hsync_in  (timing_hsync),
        .vsync_in  (timing_vsync),
        .active_in (active_display),
        .rgb_in    (pal_rgb),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .rgb       (rgb)
    );

endmodule

/* vdp_vga_timing.sv */
// VGA raster timing generator
// Horizontal and vertical phase machines, raster counters,
// registered syncs, active display and line/frame pulses

`timescale 1ns/1ps

module vdp_vga_timing (
    input  logic                           clk,
    input  logic                           rst,
    output logic [vdp_pkg::raster_x_w-1:0] raster_x,
    output logic [vdp_pkg::raster_y_w-1:0] raster_y,
    output logic                           line_ended,
    output logic                           frame_ended,
    output logic                           hsync,
    output logic                           vsync,
    output logic                           active_display
);
    import vdp_pkg::*;

    logic [1:0] x_fsm;
    logic [1:0] y_fsm;
    logic [1:0] x_fsm_nx;
    logic [1:0] y_fsm_nx;
    logic [raster_x_w-1:0] x_target;
    logic [raster_y_w-1:0] y_target;
    logic [raster_x_w-1:0] raster_x_nx;
    logic [raster_y_w-1:0] raster_y_nx;
    logic line_ended_nx;
    logic frame_ended_nx;
    logic active_display_nx;

    // Count at which each phase hands over to the next
    always_comb begin
        case (x_fsm)
            phase_fp:     x_target = raster_x_w'(h_frontporch - 1);
            phase_sync:   x_target = raster_x_w'(h_frontporch + h_sync - 1);
            phase_bp:     x_target = raster_x_w'(h_frontporch + h_sync + h_backporch - 1);
            default:      x_target = raster_x_w'(h_size - 1);
        endcase
    end

    // Vertical active comes first in the frame
    always_comb begin
        case (y_fsm)
            phase_fp:     y_target = raster_y_w'(v_active + v_frontporch - 1);
            phase_sync:   y_target = raster_y_w'(v_active + v_frontporch + v_sync - 1);
            phase_bp:     y_target = raster_y_w'(v_size - 1);
            default:      y_target = raster_y_w'(v_active - 1);
        endcase
    end

    assign x_fsm_nx = (raster_x == x_target) ? x_fsm + 2'd1 : x_fsm;
    assign line_ended_nx = x_fsm == phase_active && x_fsm_nx == phase_fp;

    assign y_fsm_nx = (line_ended_nx && raster_y == y_target) ? y_fsm + 2'd1 : y_fsm;
    assign frame_ended_nx = line_ended_nx && y_fsm == phase_bp && y_fsm_nx == phase_active;

    assign active_display_nx = y_fsm == phase_active && x_fsm_nx == phase_active;

    always_comb begin
        raster_x_nx = raster_x + 1'b1;
        raster_y_nx = raster_y;
        if (line_ended_nx) begin
            raster_x_nx = '0;
            raster_y_nx = frame_ended_nx ? '0 : raster_y + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x_fsm <= phase_fp;
            y_fsm <= phase_active;
            raster_x <= '0;
            raster_y <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            active_display <= 1'b0;
            line_ended <= 1'b0;
            frame_ended <= 1'b0;
        end else begin
            x_fsm <= x_fsm_nx;
            y_fsm <= y_fsm_nx;
            raster_x <= raster_x_nx;
            raster_y <= raster_y_nx;
            hsync <= x_fsm != phase_sync;   // Active low
            vsync <= y_fsm != phase_sync;
            active_display <= active_display_nx;
            line_ended <= line_ended_nx;
            frame_ended <= frame_ended_nx;
        end
    end

endmodule

/* vdp_video_out.sv */
// Result stage of the pixel pipeline
// Sync and active delay line matching the pixel path,
// output register with blanking

`timescale 1ns/1ps

module vdp_video_out (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hsync_in,
    input  logic                      vsync_in,
    input  logic                      active_in,
    input  logic [vdp_pkg::rgb_w-1:0] rgb_in,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      de,
    output logic [vdp_pkg::rgb_w-1:0] rgb
);
    import vdp_pkg::*;

    logic [pixel_latency-1:0] hsync_dly;
    logic [pixel_latency-1:0] vsync_dly;
    logic [pixel_latency-1:0] active_dly;

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync_dly <= '1;
            vsync_dly <= '1;
            active_dly <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de <= 1'b0;
            rgb <= '0;
        end else begin
            hsync_dly <= {hsync_dly[pixel_latency-2:0], hsync_in};
            vsync_dly <= {vsync_dly[pixel_latency-2:0], vsync_in};
            active_dly <= {active_dly[pixel_latency-2:0], active_in};
            hsync <= hsync_dly[pixel_latency-1];
            vsync <= vsync_dly[pixel_latency-1];
            de <= active_dly[pixel_latency-1];
            rgb <= active_dly[pixel_latency-1] ? rgb_in : '0;   // Blank outside active
        end
    end

endmodule

/* vdp_vram.sv */
// Video memory
// Tile map and pattern store, shared host write port,
// one registered read port each

`timescale 1ns/1ps

module vdp_vram (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic [vdp_pkg::target_w-1:0]   wr_target,
    input  logic [vdp_pkg::wr_addr_w-1:0]  wr_addr,
    input  logic [vdp_pkg::wr_data_w-1:0]  wr_data,
    input  logic [vdp_pkg::map_addr_w-1:0] map_raddr,
    output logic [vdp_pkg::map_data_w-1:0] map_rdata,
    input  logic [vdp_pkg::pat_addr_w-1:0] pat_raddr,
    output logic [vdp_pkg::pat_data_w-1:0] pat_rdata
);
    import vdp_pkg::*;

    logic [map_data_w-1:0] map_mem [2**map_addr_w];
    logic [pat_data_w-1:0] pat_mem [2**pat_addr_w];

    always_ff @(posedge clk) begin
        if (wr_en && wr_target == target_map)
            map_mem[wr_addr[map_addr_w-1:0]] <= wr_data[map_data_w-1:0];
        if (wr_en && wr_target == target_pattern)
            pat_mem[wr_addr[pat_addr_w-1:0]] <= wr_data[pat_data_w-1:0];
    end

    // Reads see the old word on a same-cycle write
    always_ff @(posedge clk) begin
        map_rdata <= map_mem[map_raddr];
        pat_rdata <= pat_mem[pat_raddr];
    end

endmodule
